// ==== common/rs_pkg.sv ====
`default_nettype none

package rs_pkg;

  parameter int WORD_W  = 32;
  parameter int REG_NUM = 64;
  parameter int REG_W   = 6;
  parameter int SLOT_W  = 6;   // up to 64 stations per bank

  typedef enum logic [1:0] {
    UNIT_ADD = 2'd0,
    UNIT_MUL = 2'd1,
    UNIT_MV  = 2'd2
  } unit_e;

  // producer kind, NONE means the register holds its value
  typedef enum logic [1:0] {
    KIND_NONE = 2'd0,
    KIND_ADD  = 2'd1,
    KIND_MUL  = 2'd2
  } kind_e;

  typedef struct packed {
    kind_e             kind;
    logic [SLOT_W-1:0] slot;
  } tag_t;

  parameter tag_t TAG_NONE = '{kind: KIND_NONE, slot: '0};

  typedef struct packed {
    logic [WORD_W-$bits(tag_t)-1:0] pad;
    tag_t                           tag;
  } wait_t;

  // value once ready, producer tag while waiting
  typedef union packed {
    logic signed [WORD_W-1:0] value;
    wait_t                    waiting;
  } operand_u;

  typedef struct packed {
    logic     ready;
    operand_u word;
  } operand_t;

  typedef struct packed {
    logic     busy;
    operand_t opa;
    operand_t opb;
  } entry_t;

  typedef struct packed {
    unit_e                    unit;
    logic [REG_W-1:0]         dst;
    logic [REG_W-1:0]         src1;
    logic [REG_W-1:0]         src2;
    logic                     has_imm;
    logic signed [WORD_W-1:0] imm;
  } issue_req_t;

  typedef struct packed {
    logic                     en;
    logic                     direct;  // immediate mv, value goes straight in
    logic [REG_W-1:0]         dst;
    tag_t                     tag;
    logic signed [WORD_W-1:0] value;
  } rename_t;

  typedef struct packed {
    logic                     valid;
    tag_t                     tag;
    logic signed [WORD_W-1:0] value;
  } cdb_t;

endpackage

`default_nettype wire

// ==== rtl/issue_router.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_router (
  input  logic                      issue_valid,
  input  rs_pkg::issue_req_t        issue,
  input  rs_pkg::operand_t          opa,
  input  rs_pkg::operand_t          opb,
  input  logic                      add_full,
  input  logic [rs_pkg::SLOT_W-1:0] add_free_slot,
  input  logic                      mul_full,
  input  logic [rs_pkg::SLOT_W-1:0] mul_free_slot,
  output logic                      issue_accept,
  output logic                      add_alloc,
  output logic                      mul_alloc,
  output rs_pkg::entry_t            entry,
  output rs_pkg::rename_t           rename
);
  import rs_pkg::*;

  logic     imm_mv;
  logic     reg_mv;
  logic     to_add;
  logic     to_mul;
  operand_t imm_op;
  operand_t zero_op;

  assign imm_mv = (issue.unit == UNIT_MV) && issue.has_imm;
  assign reg_mv = (issue.unit == UNIT_MV) && !issue.has_imm;
  assign to_add = (issue.unit == UNIT_ADD) || reg_mv;
  assign to_mul = (issue.unit == UNIT_MUL);

  assign add_alloc    = issue_valid && to_add && !add_full;
  assign mul_alloc    = issue_valid && to_mul && !mul_full;
  assign issue_accept = add_alloc || mul_alloc || (issue_valid && imm_mv);

  always_comb begin
    imm_op.ready       = 1'b1;
    imm_op.word.value  = issue.imm;
    zero_op.ready      = 1'b1;
    zero_op.word.value = '0;
  end

  // mv copies src1, add with zero
  always_comb begin
    entry.busy = 1'b1;
    entry.opa  = opa;
    if (reg_mv) begin
      entry.opb = zero_op;
    end else if (issue.has_imm) begin
      entry.opb = imm_op;
    end else begin
      entry.opb = opb;
    end
  end

  always_comb begin
    rename.en     = issue_accept;
    rename.direct = imm_mv;
    rename.dst    = issue.dst;
    rename.value  = issue.imm;
    if (imm_mv) begin
      rename.tag = TAG_NONE;
    end else if (to_mul) begin
      rename.tag = '{kind: KIND_MUL, slot: mul_free_slot};
    end else begin
      rename.tag = '{kind: KIND_ADD, slot: add_free_slot};
    end
  end

endmodule

`default_nettype wire

// ==== station_bank/station_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module station_bank #(
  parameter int            DEPTH = 8,
  parameter rs_pkg::kind_e UNIT  = rs_pkg::KIND_ADD
) (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      alloc,
  input  rs_pkg::entry_t            entry_in,
  input  rs_pkg::cdb_t              add_cdb,
  input  rs_pkg::cdb_t              mul_cdb,
  output logic                      full,
  output logic [rs_pkg::SLOT_W-1:0] free_slot,
  output rs_pkg::cdb_t              cdb
);
  import rs_pkg::*;

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [DEPTH-1:0]         busy;
  operand_t                 opa_q [DEPTH];
  operand_t                 opb_q [DEPTH];
  logic [DEPTH-1:0]         ready;
  logic [IDX_W-1:0]         free_idx;
  logic [IDX_W-1:0]         fire_idx;
  logic                     fire;
  logic signed [WORD_W-1:0] src_a;
  logic signed [WORD_W-1:0] src_b;
  logic signed [WORD_W-1:0] alu_res;
  logic                     cdb_valid_q;
  tag_t                     cdb_tag_q;
  logic signed [WORD_W-1:0] cdb_value_q;

  // capture a broadcast value for a waiting operand
  function automatic operand_t wake(input operand_t op, input cdb_t a, input cdb_t m);
    operand_t res;
    res = op;
    if (!op.ready) begin
      if (a.valid && a.tag == op.word.waiting.tag) begin
        res.ready      = 1'b1;
        res.word.value = a.value;
      end else if (m.valid && m.tag == op.word.waiting.tag) begin
        res.ready      = 1'b1;
        res.word.value = m.value;
      end
    end
    return res;
  endfunction

  always_comb begin
    free_idx = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!busy[i]) free_idx = IDX_W'(i);  // lowest free wins
    end
  end

  assign full      = &busy;
  assign free_slot = SLOT_W'(free_idx);

  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      ready[i] = busy[i] && opa_q[i].ready && opb_q[i].ready;
    end
  end

  always_comb begin
    fire_idx = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (ready[i]) fire_idx = IDX_W'(i);
    end
  end

  assign fire  = |ready;
  assign src_a = opa_q[fire_idx].word.value;
  assign src_b = opb_q[fire_idx].word.value;

  // one shared unit per bank, low word only
  if (UNIT == KIND_MUL) begin : g_mul
    assign alu_res = src_a * src_b;
  end else begin : g_add
    assign alu_res = src_a + src_b;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy <= '0;
    end else begin
      if (fire) busy[fire_idx] <= 1'b0;
      if (alloc) busy[free_idx] <= entry_in.busy;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (alloc && free_idx == IDX_W'(i)) begin
        opa_q[i] <= entry_in.opa;
        opb_q[i] <= entry_in.opb;
      end else begin
        opa_q[i] <= wake(opa_q[i], add_cdb, mul_cdb);
        opb_q[i] <= wake(opb_q[i], add_cdb, mul_cdb);
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cdb_valid_q <= 1'b0;
    end else begin
      cdb_valid_q <= fire;  // single cycle pulse per result
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      cdb_tag_q   <= '{kind: UNIT, slot: SLOT_W'(fire_idx)};
      cdb_value_q <= alu_res;
    end
  end

  assign cdb = '{valid: cdb_valid_q, tag: cdb_tag_q, value: cdb_value_q};

endmodule

`default_nettype wire

// ==== reg_status/reg_status.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_status (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic [rs_pkg::REG_W-1:0]  src1,
  input  logic [rs_pkg::REG_W-1:0]  src2,
  input  rs_pkg::rename_t           rename,
  input  rs_pkg::cdb_t              add_cdb,
  input  rs_pkg::cdb_t              mul_cdb,
  input  logic [rs_pkg::REG_W-1:0]  rd_sel,
  output rs_pkg::operand_t          opa,
  output rs_pkg::operand_t          opb,
  output rs_pkg::tag_t              rd_tag,
  output logic [rs_pkg::WORD_W-1:0] rd_value
);
  import rs_pkg::*;

  tag_t              tag_q [REG_NUM];
  logic [WORD_W-1:0] rf_q  [REG_NUM];

  // ready value, bus bypass, or producer tag
  function automatic operand_t lookup(
    input tag_t              t,
    input logic [WORD_W-1:0] v,
    input cdb_t              a,
    input cdb_t              m
  );
    operand_t res;
    res.ready      = 1'b1;
    res.word.value = v;
    if (t.kind != KIND_NONE) begin
      if (a.valid && a.tag == t) begin
        res.word.value = a.value;
      end else if (m.valid && m.tag == t) begin
        res.word.value = m.value;
      end else begin
        res.ready             = 1'b0;
        res.word.waiting.pad = '0;
        res.word.waiting.tag = t;
      end
    end
    return res;
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int r = 0; r < REG_NUM; r++) begin
        tag_q[r] <= TAG_NONE;
        rf_q[r]  <= '0;
      end
    end else begin
      for (int r = 0; r < REG_NUM; r++) begin
        if (add_cdb.valid && tag_q[r] == add_cdb.tag) begin
          tag_q[r] <= TAG_NONE;
          rf_q[r]  <= add_cdb.value;
        end
        if (mul_cdb.valid && tag_q[r] == mul_cdb.tag) begin
          tag_q[r] <= TAG_NONE;
          rf_q[r]  <= mul_cdb.value;
        end
      end
      // rename last so it beats a broadcast on dst
      if (rename.en) begin
        tag_q[rename.dst] <= rename.tag;
        if (rename.direct) rf_q[rename.dst] <= rename.value;
      end
    end
  end

  always_comb begin
    opa = lookup(tag_q[src1], rf_q[src1], add_cdb, mul_cdb);
    opb = lookup(tag_q[src2], rf_q[src2], add_cdb, mul_cdb);
  end

  assign rd_tag   = tag_q[rd_sel];  // no bypass on the read port
  assign rd_value = rf_q[rd_sel];

endmodule

`default_nettype wire

// ==== rtl/tomasulo_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tomasulo_core #(
  parameter int DEPTH_ADD = 8,
  parameter int DEPTH_MUL = 4
) (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      issue_valid,
  input  rs_pkg::issue_req_t        issue,
  output logic                      issue_accept,
  input  logic [rs_pkg::REG_W-1:0]  rd_sel,
  output rs_pkg::tag_t              rd_tag,
  output logic [rs_pkg::WORD_W-1:0] rd_value
);
  import rs_pkg::*;

  operand_t          opa;
  operand_t          opb;
  entry_t            entry;
  rename_t           rename;
  logic              add_alloc;
  logic              mul_alloc;
  logic              add_full;
  logic              mul_full;
  logic [SLOT_W-1:0] add_free_slot;
  logic [SLOT_W-1:0] mul_free_slot;
  cdb_t              add_cdb;
  cdb_t              mul_cdb;

  issue_router u_router (
    .issue_valid   (issue_valid),
    .issue         (issue),
    .opa           (opa),
    .opb           (opb),
    .add_full      (add_full),
    .add_free_slot (add_free_slot),
    .mul_full      (mul_full),
    .mul_free_slot (mul_free_slot),
    .issue_accept  (issue_accept),
    .add_alloc     (add_alloc),
    .mul_alloc     (mul_alloc),
    .entry         (entry),
    .rename        (rename)
  );

  // add bank also carries register mv
  station_bank #(
    .DEPTH (DEPTH_ADD),
    .UNIT  (KIND_ADD)
  ) u_add (
    .clk       (clk),
    .arst_n    (arst_n),
    .alloc     (add_alloc),
    .entry_in  (entry),
    .add_cdb   (add_cdb),
    .mul_cdb   (mul_cdb),
    .full      (add_full),
    .free_slot (add_free_slot),
    .cdb       (add_cdb)
  );

  station_bank #(
    .DEPTH (DEPTH_MUL),
    .UNIT  (KIND_MUL)
  ) u_mul (
    .clk       (clk),
    .arst_n    (arst_n),
    .alloc     (mul_alloc),
    .entry_in  (entry),
    .add_cdb   (add_cdb),
    .mul_cdb   (mul_cdb),
    .full      (mul_full),
    .free_slot (mul_free_slot),
    .cdb       (mul_cdb)
  );

  reg_status u_reg_status (
    .clk      (clk),
    .arst_n   (arst_n),
    .src1     (issue.src1),
    .src2     (issue.src2),
    .rename   (rename),
    .add_cdb  (add_cdb),
    .mul_cdb  (mul_cdb),
    .rd_sel   (rd_sel),
    .opa      (opa),
    .opb      (opb),
    .rd_tag   (rd_tag),
    .rd_value (rd_value)
  );

endmodule

`default_nettype wire

// ==== dv/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns: name, request (unit dst src1 src2 has_imm imm), check flag, register,
// expected value, expected from model, tag kind right after issue, burst marker
localparam int N_FIXED        = 20;
localparam int N_RANDOM       = 12;
localparam int N_ROWS         = N_FIXED + N_RANDOM;
localparam int TIMEOUT_CYCLES = 40 * N_ROWS + 8 + REG_NUM;  // rows, reset, final sweep

typedef struct packed {
  issue_req_t        req;
  logic              chk;
  logic [REG_W-1:0]  reg_idx;
  logic [WORD_W-1:0] exp;
  logic              fill;   // expected comes from the model
  kind_e             pend;   // tag kind right after the issue edge
  logic [1:0]        burst;  // 1 opens, 2 closes a full-bank burst
} row_t;

string names [N_ROWS];
row_t  rows  [N_ROWS];
int    n_rows = 0;

function automatic issue_req_t make_req(input unit_e unit, input int dst, input int src1,
                                        input int src2, input int has_imm, input int imm);
  issue_req_t r;
  r.unit    = unit;
  r.dst     = REG_W'(dst);
  r.src1    = REG_W'(src1);
  r.src2    = REG_W'(src2);
  r.has_imm = (has_imm != 0);
  r.imm     = imm;
  return r;
endfunction

task automatic add_row(input string name, input issue_req_t req, input int chk,
                       input int reg_idx, input logic [WORD_W-1:0] exp, input int fill,
                       input kind_e pend, input int burst);
  row_t row;
  row.req     = req;
  row.chk     = (chk != 0);
  row.reg_idx = REG_W'(reg_idx);
  row.exp     = exp;
  row.fill    = (fill != 0);
  row.pend    = pend;
  row.burst   = 2'(burst);
  names[n_rows] = name;
  rows[n_rows]  = row;
  n_rows++;
endtask

task automatic load_fixed_rows();
  add_row("mv_imm_r1", make_req(UNIT_MV, 1, 0, 0, 1, 100), 1, 1, 100, 0, KIND_NONE, 0);
  add_row("mv_imm_r2", make_req(UNIT_MV, 2, 0, 0, 1, -7),
          1, 2, 32'hffff_fff9, 0, KIND_NONE, 0);
  add_row("add_rr", make_req(UNIT_ADD, 10, 1, 2, 0, 0), 1, 10, '0, 1, KIND_NONE, 0);
  add_row("mv_imm_r8", make_req(UNIT_MV, 8, 0, 0, 1, 32'h7fff_fff0),
          0, 8, '0, 0, KIND_NONE, 0);
  add_row("add_imm_wrap", make_req(UNIT_ADD, 9, 8, 0, 1, 32'h20),
          1, 9, 32'h8000_0010, 0, KIND_NONE, 0);  // signed overflow
  // back to back, r4 waits on the mul
  add_row("chain_mul", make_req(UNIT_MUL, 3, 1, 2, 0, 0), 0, 3, '0, 0, KIND_NONE, 0);
  add_row("chain_add", make_req(UNIT_ADD, 4, 3, 0, 1, 5), 1, 4, '0, 1, KIND_ADD, 0);
  add_row("mv_src_mul", make_req(UNIT_MUL, 6, 1, 0, 1, 3), 0, 6, '0, 0, KIND_NONE, 0);
  add_row("mv_reg", make_req(UNIT_MV, 7, 6, 0, 0, 0), 1, 7, '0, 1, KIND_NONE, 0);
  // short add chain so the first mul of the burst stalls
  add_row("burst_head0", make_req(UNIT_ADD, 5, 1, 0, 1, 2), 0, 5, '0, 0, KIND_NONE, 0);
  add_row("burst_head1", make_req(UNIT_ADD, 5, 5, 0, 1, 3), 0, 5, '0, 0, KIND_NONE, 0);
  add_row("burst_head2", make_req(UNIT_ADD, 5, 5, 0, 1, 5), 0, 5, '0, 0, KIND_NONE, 0);
  for (int i = 0; i < 8; i++) begin
    add_row($sformatf("burst_mul%0d", i), make_req(UNIT_MUL, 5, 5, 0, 1, 3),
            (i == 7) ? 1 : 0, 5, '0, 1, KIND_NONE, (i == 0) ? 1 : ((i == 7) ? 2 : 0));
  end
endtask

`endif

// ==== dv/tb_tomasulo_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_tomasulo_core;
  import rs_pkg::*;

  logic              clk;
  logic              arst_n;
  logic              issue_valid;
  issue_req_t        issue;
  logic              issue_accept;
  logic [REG_W-1:0]  rd_sel;
  tag_t              rd_tag;
  logic [WORD_W-1:0] rd_value;

  logic [WORD_W-1:0] model [REG_NUM];  // architectural state in program order
  int                refusals = 0;
  int                cycles   = 0;
  int                seed     = 32'h8ada_54fc;

  `include "tb_vectors.svh"

  tomasulo_core #(
    .DEPTH_ADD (8),
    .DEPTH_MUL (4)
  ) tomasulo_core_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .issue_valid  (issue_valid),
    .issue        (issue),
    .issue_accept (issue_accept),
    .rd_sel       (rd_sel),
    .rd_tag       (rd_tag),
    .rd_value     (rd_value)
  );

  always #20 clk = ~clk;

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [WORD_W-1:0] exp,
                       input logic [WORD_W-1:0] act);
    if (act !== exp) begin
      stop_with_failure($sformatf("MISMATCH %s expected %08h actual %08h", name, exp, act));
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      stop_with_failure($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  // add, mul and mv with 32 bit wrap
  function automatic logic [WORD_W-1:0] model_result(input issue_req_t req);
    logic [WORD_W-1:0] a;
    logic [WORD_W-1:0] b;
    a = model[req.src1];
    b = req.has_imm ? req.imm : model[req.src2];
    case (req.unit)
      UNIT_ADD: return a + b;
      UNIT_MUL: return a * b;
      default:  return req.has_imm ? req.imm : a;
    endcase
  endfunction

  task automatic load_random_rows();
    issue_req_t        req;
    logic [WORD_W-1:0] rnd;
    for (int i = 0; i < N_RANDOM; i++) begin
      rnd         = $random(seed);
      req.unit    = rnd[0] ? UNIT_MUL : UNIT_ADD;
      req.dst     = rnd[6:1];
      req.src1    = rnd[12:7];
      req.src2    = rnd[18:13];
      req.has_imm = rnd[19];
      req.imm     = $random(seed);
      add_row($sformatf("random_%0d", i), req, 0, 0, '0, 0, KIND_NONE, 0);
    end
  endtask

  // wait until the register has no producer, then compare
  task automatic drain_and_check(input string name, input logic [REG_W-1:0] idx,
                                 input logic [WORD_W-1:0] exp);
    rd_sel = idx;
    @(negedge clk);
    while (rd_tag.kind != KIND_NONE) @(negedge clk);
    check(name, exp, rd_value);
    @(posedge clk);
    #2;
  endtask

  task automatic apply_row(input int idx);
    row_t row;
    logic accepted;
    row = rows[idx];
    if (row.burst == 2'd1) refusals = 0;
    rd_sel      = row.reg_idx;
    issue       = row.req;
    issue_valid = 1'b1;
    accepted    = 1'b0;
    while (!accepted) begin  // refused rows go again next cycle
      @(negedge clk);
      accepted = issue_accept;
      if (!accepted) refusals++;
      @(posedge clk);
      #2;
    end
    issue_valid = 1'b0;
    model[row.req.dst] = model_result(row.req);
    if (row.fill) row.exp = model[row.reg_idx];
    if (row.pend != KIND_NONE) begin
      check({names[idx], "_tag"}, WORD_W'(row.pend), WORD_W'(rd_tag.kind));
    end
    if (row.burst == 2'd2 && refusals == 0) begin
      stop_with_failure("mul bank never refused an issue during the back-to-back burst");
    end
    if (row.chk) drain_and_check(names[idx], row.reg_idx, row.exp);
  endtask

  initial begin
    clk         = 1'b0;
    arst_n      = 1'b0;
    issue_valid = 1'b0;
    issue       = '0;
    rd_sel      = '0;
    for (int r = 0; r < REG_NUM; r++) model[r] = '0;
    load_fixed_rows();
    load_random_rows();
    repeat (8) @(posedge clk);
    #2;
    arst_n = 1'b1;
    for (int i = 0; i < n_rows; i++) apply_row(i);
    // every register against the model
    for (int r = 0; r < REG_NUM; r++) begin
      drain_and_check($sformatf("sweep_r%0d", r), REG_W'(r), model[r]);
    end
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+dv
common/rs_pkg.sv
rtl/issue_router.sv
station_bank/station_bank.sv
reg_status/reg_status.sv
rtl/tomasulo_core.sv
dv/tb_tomasulo_core.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := tb_tomasulo_core
FILELIST  := sim.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: sim clean

# $fatal in the testbench gives a nonzero exit status, which fails this target
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
